// ==== dv/serial_stimulus.txt ====
# name op id burst addr count words
# op W writes the words, op R expects them back, addr and words in hex
single_wr  W 1 0 005 1 a5c31e7f
single_rd  R 1 0 005 1 a5c31e7f
burst_wr   W 1 1 100 4 01234567 89abcdef deadbeef 76543210
burst_rd   R 1 1 100 4 01234567 89abcdef deadbeef 76543210
gap_wr     W 1 0 3ff 1 f0f0a55a
gap_rd     R 1 0 3ff 1 f0f0a55a
foreign_wr W 2 0 005 1 00000000
keep_rd    R 1 0 005 1 a5c31e7f
mid_rd     R 1 1 101 2 89abcdef deadbeef
top_wr     W 1 1 7cd 3 0badf00d 13579bdf 2468ace0
top_rd     R 1 1 7cd 3 0badf00d 13579bdf 2468ace0

// ==== dv/slave_checker.sv ====
// Read data checker
`timescale 1ns/10ps
`default_nettype none

module slave_checker (
    input  logic             clk,
    input  logic             rstN,
    input  logic             ready,
    input  logic             rD,
    input  logic             exp_push,
    input  logic             exp_first,
    input  logic [8*16-1:0]  exp_name,
    input  slave_pkg::word_t exp_word,
    output int               data_errors,
    output int               timing_errors,
    output int               words_checked
);

    typedef enum logic [1:0] {
        WAIT_READ,
        NEXT_LOW,
        LOW,
        BITS
    } phase_t;

    logic [8*16-1:0]  name_q  [64];
    slave_pkg::word_t word_q  [64];
    logic             first_q [64];
    int               head = 0;
    int               tail = 0;
    phase_t           phase = WAIT_READ;
    int               low_cnt = 0;
    int               bit_cnt = 0;
    slave_pkg::word_t got;
    logic             in_reset = 1'b1;
    logic             out_of_reset = 1'b0;

    assign words_checked = head;

    // expected words arrive from the driver between falling edges
    always @(posedge clk) begin
        // reset level as the DUT sees it at this edge
        out_of_reset = rstN;
        if (exp_push) begin
            name_q[tail]  = exp_name;
            word_q[tail]  = exp_word;
            first_q[tail] = exp_first;
            tail = tail + 1;
        end
    end

    // ready and rD are stable at the falling edge
    always @(negedge clk) begin
        if (!out_of_reset) begin
            in_reset      = 1'b1;
            phase         = WAIT_READ;
            data_errors   = 0;
            timing_errors = 0;
        end else begin
            if (in_reset && !ready) begin
                $display("ready is low right after reset");
                timing_errors++;
            end
            in_reset = 1'b0;
            case (phase)
                WAIT_READ: begin
                    if (!ready && head != tail) begin
                        phase   = LOW;
                        low_cnt = 1;
                    end else if (!ready) begin
                        $display("ready went low with no read in progress");
                        timing_errors++;
                    end
                end
                // a burst goes straight on to the next fetch
                NEXT_LOW: begin
                    if (ready) begin
                        $display("ready stayed high between burst words of test %0s",
                                 name_q[head]);
                        timing_errors++;
                        phase = WAIT_READ;
                    end else begin
                        phase   = LOW;
                        low_cnt = 1;
                    end
                end
                LOW: begin
                    if (!ready) begin
                        low_cnt++;
                        if (low_cnt == 3) begin
                            $display("ready low for more than 2 cycles in test %0s",
                                     name_q[head]);
                            timing_errors++;
                        end
                    end else begin
                        if (low_cnt < 2) begin
                            $display("ready low for only %0d cycle in test %0s",
                                     low_cnt, name_q[head]);
                            timing_errors++;
                        end
                        got     = slave_pkg::word_t'(rD);
                        bit_cnt = 1;
                        phase   = BITS;
                    end
                end
                BITS: begin
                    if (!ready) begin
                        $display("ready fell after %0d of %0d bits in test %0s",
                                 bit_cnt, bus_pkg::DATA_W, name_q[head]);
                        timing_errors++;
                        phase   = LOW;
                        low_cnt = 1;
                    end else begin
                        got = {got[bus_pkg::DATA_W-2:0], rD};
                        bit_cnt++;
                    end
                end
                default: begin
                    phase = WAIT_READ;
                end
            endcase
            if (phase == BITS && bit_cnt == bus_pkg::DATA_W) begin
                if (got !== word_q[head]) begin
                    $display("error: test %0s expected %08h actual %08h",
                             name_q[head], word_q[head], got);
                    data_errors++;
                end
                head    = head + 1;
                bit_cnt = 0;
                phase   = (head != tail && !first_q[head]) ? NEXT_LOW : WAIT_READ;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_serial_slave.sv ====
// Serial slave testbench
`timescale 1ns/10ps
`default_nettype none

module tb_serial_slave;

    localparam bus_pkg::slave_id_t SLAVE_ID = 2'd1;
    localparam int MEM_DEPTH = 2000;
    localparam int MAX_TESTS = 32;
    localparam int MAX_WORDS = 128;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    logic             exp_push;
    logic             exp_first;
    logic [8*16-1:0]  exp_name;
    slave_pkg::word_t exp_word;
    int               data_errors;
    int               timing_errors;
    int               words_checked;

    // test table filled from the stimulus file
    logic [8*16-1:0]  t_name  [MAX_TESTS];
    logic [7:0]       t_op    [MAX_TESTS];
    int               t_id    [MAX_TESTS];
    int               t_burst [MAX_TESTS];
    int               t_addr  [MAX_TESTS];
    int               t_count [MAX_TESTS];
    int               t_first [MAX_TESTS];
    slave_pkg::word_t words   [MAX_WORDS];
    int               n_tests;
    int               n_words;
    int               words_expected;
    int               other_errors;
    int               timeout_limit;
    int               cycle_cnt = 0;
    int               seed;

    serial_slave_top #(
        .SLAVE_ID  (SLAVE_ID),
        .MEM_DEPTH (MEM_DEPTH)
    ) i_serial_slave_top (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    slave_checker i_slave_checker (
        .clk           (clk),
        .rstN          (rstN),
        .ready         (ready),
        .rD            (rD),
        .exp_push      (exp_push),
        .exp_first     (exp_first),
        .exp_name      (exp_name),
        .exp_word      (exp_word),
        .data_errors   (data_errors),
        .timing_errors (timing_errors),
        .words_checked (words_checked)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout after %0d cycles, data errors %0d, timing errors %0d",
                     cycle_cnt, data_errors, timing_errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic load_stimulus();
        int               fd;
        int               r;
        int               i;
        int               id;
        int               burst;
        int               addr;
        int               count;
        logic [8*16-1:0]  tok;
        logic [7:0]       op;
        logic [8*160-1:0] rest;
        slave_pkg::word_t w;
        n_tests = 0;
        n_words = 0;
        timeout_limit = 16;
        fd = $fopen("dv/serial_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file dv/serial_stimulus.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                r = $fscanf(fd, "%s", tok);
                if (r == 1 && tok == (8*16)'("#")) begin
                    r = $fgets(rest, fd);
                end else if (r == 1) begin
                    r = $fscanf(fd, "%s %d %d %h %d", op, id, burst, addr, count);
                    t_name[n_tests]  = tok;
                    t_op[n_tests]    = op;
                    t_id[n_tests]    = id;
                    t_burst[n_tests] = burst;
                    t_addr[n_tests]  = addr;
                    t_count[n_tests] = count;
                    t_first[n_tests] = n_words;
                    for (i = 0; i < count; i++) begin
                        r = $fscanf(fd, "%h", w);
                        words[n_words] = w;
                        n_words++;
                    end
                    timeout_limit += bus_pkg::HDR_LEN + 4 + (bus_pkg::DATA_W + 4) * count;
                    n_tests++;
                end
            end
            $fclose(fd);
        end
        // room for the random valid gaps
        timeout_limit = timeout_limit * 2;
    endtask

    task automatic send_header(input int id, input logic write, input int burst,
                               input int addr);
        logic [bus_pkg::HDR_LEN-1:0] hdr;
        int                          b;
        hdr = {bus_pkg::START_CODE, bus_pkg::slave_id_t'(id), write, burst[0],
               slave_pkg::addr_t'(addr)};
        for (b = bus_pkg::HDR_LEN - 1; b >= 0; b--) begin
            @(negedge clk);
            control = hdr[b];
        end
        @(negedge clk);
        control = 1'b0;
    endtask

    task automatic write_words(input int first, input int count, input int burst);
        int               w;
        int               b;
        slave_pkg::word_t data;
        for (w = 0; w < count; w++) begin
            data = words[first + w];
            for (b = bus_pkg::DATA_W - 1; b >= 0; b--) begin
                if (($random(seed) & 3) == 0) begin
                    @(negedge clk);
                    valid = 1'b0;
                end
                @(negedge clk);
                valid = 1'b1;
                wD    = data[b];
                last  = (burst != 0) && (w == count - 1) && (b == 0);
            end
            // store cycle where no bit is taken
            @(negedge clk);
            valid = 1'b0;
            wD    = 1'b0;
            last  = 1'b0;
        end
    endtask

    task automatic wait_ready(input logic level);
        do begin
            @(negedge clk);
        end while (ready != level);
    endtask

    task automatic read_words(input int count);
        int w;
        for (w = 0; w < count; w++) begin
            wait_ready(1'b0);
            wait_ready(1'b1);
            last = (w == count - 1);
            repeat (bus_pkg::DATA_W) @(negedge clk);
            last = 1'b0;
        end
    endtask

    task automatic push_expected(input int t);
        int w;
        for (w = 0; w < t_count[t]; w++) begin
            @(negedge clk);
            exp_push  = 1'b1;
            exp_first = (w == 0);
            exp_name  = t_name[t];
            exp_word  = words[t_first[t] + w];
        end
        @(negedge clk);
        exp_push = 1'b0;
        words_expected += t_count[t];
    endtask

    initial begin
        int t;
        rstN           = 1'b0;
        control        = 1'b0;
        wD             = 1'b0;
        valid          = 1'b0;
        last           = 1'b0;
        exp_push       = 1'b0;
        exp_first      = 1'b0;
        exp_name       = '0;
        exp_word       = '0;
        seed           = 49;
        words_expected = 0;
        other_errors   = 0;
        load_stimulus();
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        repeat (4) @(negedge clk);
        for (t = 0; t < n_tests; t++) begin
            if (t_op[t] == "R" && t_id[t] == int'(SLAVE_ID)) begin
                push_expected(t);
                send_header(t_id[t], 1'b0, t_burst[t], t_addr[t]);
                read_words(t_count[t]);
            end else if (t_op[t] == "R") begin
                send_header(t_id[t], 1'b0, t_burst[t], t_addr[t]);
            end else begin
                send_header(t_id[t], 1'b1, t_burst[t], t_addr[t]);
                write_words(t_first[t], t_count[t], t_burst[t]);
            end
            repeat (4) @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (words_checked != words_expected) begin
            $display("only %0d of %0d expected read words arrived",
                     words_checked, words_expected);
            other_errors++;
        end
        $display("data errors %0d, timing errors %0d, other errors %0d",
                 data_errors, timing_errors, other_errors);
        if (data_errors + timing_errors + other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_serial_slave -f src.f
./obj_dir/Vtb_serial_slave | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== src.f ====
verilog/bus_pkg.sv
verilog/slave_pkg.sv
verilog/config_receiver.sv
verilog/slave_controller.sv
verilog/data_shifter.sv
verilog/slave_memory.sv
verilog/serial_slave_top.sv
dv/slave_checker.sv
dv/tb_serial_slave.sv

// ==== verilog/bus_pkg.sv ====
// Serial bus protocol definitions
`default_nettype none

package bus_pkg;

    // data word and address widths on the serial lines
    localparam int DATA_W = 32;
    localparam int ADDR_W = 11;
    localparam int ID_W = 2;

    // header start code, sent first
    localparam int START_W = 3;
    localparam logic [START_W-1:0] START_CODE = 3'b111;

    // start | id | write | burst | address, MSB first
    localparam int HDR_LEN = START_W + ID_W + 2 + ADDR_W;

    typedef logic [ID_W-1:0] slave_id_t;

    // decoded transaction request, the low bits of the header
    typedef struct packed {
        logic              write;
        logic              burst;
        // start address, same width as the memory address
        logic [ADDR_W-1:0] addr;
    } cmd_t;

endpackage

`default_nettype wire

// ==== verilog/config_receiver.sv ====
// Serial header receiver
`timescale 1ns/10ps
`default_nettype none

module config_receiver #(
    parameter bus_pkg::slave_id_t SLAVE_ID = 2'd1
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          control,
    input  logic          busy,
    output bus_pkg::cmd_t cmd,
    output logic          cmd_valid
);

    localparam int CNT_W = $clog2(bus_pkg::HDR_LEN);
    localparam int ID_MSB = bus_pkg::HDR_LEN - bus_pkg::START_W - 1;

    logic [bus_pkg::HDR_LEN-1:0] hdr_sr;
    logic [bus_pkg::HDR_LEN-1:0] hdr_next;
    logic [CNT_W-1:0]            hdr_cnt;
    logic                        active;
    logic                        hdr_match;

    // header as it stands once the current control bit is taken
    assign hdr_next = {hdr_sr[bus_pkg::HDR_LEN-2:0], control};

    assign hdr_match = (hdr_next[bus_pkg::HDR_LEN-1 -: bus_pkg::START_W] == bus_pkg::START_CODE)
                    && (hdr_next[ID_MSB -: bus_pkg::ID_W] == SLAVE_ID);

    always_ff @(posedge clk) begin
        if (active || (!busy && control)) begin
            hdr_sr <= hdr_next;
        end
        if (active && hdr_cnt == CNT_W'(bus_pkg::HDR_LEN - 1)) begin
            cmd <= bus_pkg::cmd_t'(hdr_next[$bits(bus_pkg::cmd_t)-1:0]);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active    <= 1'b0;
            hdr_cnt   <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (!active) begin
                // first high control bit while idle opens a header
                if (!busy && control) begin
                    active  <= 1'b1;
                    hdr_cnt <= CNT_W'(1);
                end
            end else if (hdr_cnt == CNT_W'(bus_pkg::HDR_LEN - 1)) begin
                active    <= 1'b0;
                hdr_cnt   <= '0;
                // foreign or malformed headers are dropped silently
                cmd_valid <= hdr_match;
            end else begin
                hdr_cnt <= hdr_cnt + CNT_W'(1);
            end
        end
    end

    // one command per header
    cmd_valid_single: assert property (@(posedge clk) disable iff (!rstN)
        cmd_valid |=> !cmd_valid)
        else $error("cmd_valid held high for more than one cycle");

endmodule

`default_nettype wire

// ==== verilog/data_shifter.sv ====
// Read and write data shift registers
`timescale 1ns/10ps
`default_nettype none

module data_shifter (
    input  logic             clk,
    input  logic             rstN,
    input  slave_pkg::word_t rd_word,
    input  logic             load_rd,
    input  logic             shift_rd,
    input  logic             shift_wr,
    input  logic             wD,
    output logic             rD,
    output logic             rd_done,
    output logic             wr_done,
    output slave_pkg::word_t wr_word
);

    slave_pkg::word_t    rd_sr;
    slave_pkg::word_t    wr_sr;
    slave_pkg::bit_cnt_t rd_cnt;
    slave_pkg::bit_cnt_t wr_cnt;

    // done while the DATA_W-th bit moves
    assign rd_done = shift_rd && (rd_cnt == slave_pkg::bit_cnt_t'(bus_pkg::DATA_W - 1));
    assign wr_done = shift_wr && (wr_cnt == slave_pkg::bit_cnt_t'(bus_pkg::DATA_W - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rd_sr  <= '0;
            rd_cnt <= '0;
            wr_cnt <= '0;
        end else begin
            if (load_rd) begin
                rd_sr  <= rd_word;
                rd_cnt <= '0;
            end else if (shift_rd) begin
                rd_sr  <= {rd_sr[bus_pkg::DATA_W-2:0], 1'b0};
                rd_cnt <= rd_done ? '0 : rd_cnt + slave_pkg::bit_cnt_t'(1);
            end
            if (shift_wr) begin
                wr_cnt <= wr_done ? '0 : wr_cnt + slave_pkg::bit_cnt_t'(1);
            end
        end
    end

    // msb first, new bits enter at the lsb
    always_ff @(posedge clk) begin
        if (shift_wr) begin
            wr_sr <= {wr_sr[bus_pkg::DATA_W-2:0], wD};
        end
    end

    assign rD      = rd_sr[bus_pkg::DATA_W-1];
    assign wr_word = wr_sr;

    load_shift_excl: assert property (@(posedge clk) disable iff (!rstN)
        !(load_rd && shift_rd))
        else $error("read word loaded while shifting");

endmodule

`default_nettype wire

// ==== verilog/serial_slave_top.sv ====
// Serial bus slave top level
`timescale 1ns/10ps
`default_nettype none

module serial_slave_top #(
    parameter bus_pkg::slave_id_t SLAVE_ID = 2'd1,
    parameter int MEM_DEPTH = 2000
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);

    bus_pkg::cmd_t    cmd;
    logic             cmd_valid;
    logic             busy;
    logic             load_rd;
    logic             shift_rd;
    logic             shift_wr;
    logic             mem_we;
    logic             rd_done;
    logic             wr_done;
    slave_pkg::addr_t mem_addr;
    slave_pkg::word_t rd_word;
    slave_pkg::word_t wr_word;

    config_receiver #(
        .SLAVE_ID (SLAVE_ID)
    ) i_config_receiver (
        .clk       (clk),
        .rstN      (rstN),
        .control   (control),
        .busy      (busy),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    slave_controller i_slave_controller (
        .clk       (clk),
        .rstN      (rstN),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .valid     (valid),
        .last      (last),
        .rd_done   (rd_done),
        .wr_done   (wr_done),
        .busy      (busy),
        .ready     (ready),
        .load_rd   (load_rd),
        .shift_rd  (shift_rd),
        .shift_wr  (shift_wr),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr)
    );

    data_shifter i_data_shifter (
        .clk      (clk),
        .rstN     (rstN),
        .rd_word  (rd_word),
        .load_rd  (load_rd),
        .shift_rd (shift_rd),
        .shift_wr (shift_wr),
        .wD       (wD),
        .rD       (rD),
        .rd_done  (rd_done),
        .wr_done  (wr_done),
        .wr_word  (wr_word)
    );

    slave_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_slave_memory (
        .clk   (clk),
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (wr_word),
        .rdata (rd_word)
    );

endmodule

`default_nettype wire

// ==== verilog/slave_controller.sv ====
// Slave transaction controller
`timescale 1ns/10ps
`default_nettype none

module slave_controller (
    input  logic             clk,
    input  logic             rstN,
    input  bus_pkg::cmd_t    cmd,
    input  logic             cmd_valid,
    input  logic             valid,
    input  logic             last,
    input  logic             rd_done,
    input  logic             wr_done,
    output logic             busy,
    output logic             ready,
    output logic             load_rd,
    output logic             shift_rd,
    output logic             shift_wr,
    output logic             mem_we,
    output slave_pkg::addr_t mem_addr
);

    slave_pkg::slave_state_t state;
    slave_pkg::addr_t        addr;
    logic                    burst;
    // last seen during the current word
    logic                    last_seen;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= slave_pkg::IDLE;
            addr      <= '0;
            burst     <= 1'b0;
            last_seen <= 1'b0;
            ready     <= 1'b1;
        end else begin
            case (state)
                slave_pkg::IDLE: begin
                    if (cmd_valid) begin
                        addr      <= cmd.addr;
                        burst     <= cmd.burst;
                        last_seen <= 1'b0;
                        // ready drops only while a read word is being fetched
                        ready     <= cmd.write;
                        state     <= cmd.write ? slave_pkg::WRITE_SHIFT
                                               : slave_pkg::READ_FETCH;
                    end
                end
                // address goes to memory here and data arrives in READ_LOAD
                slave_pkg::READ_FETCH: begin
                    state <= slave_pkg::READ_LOAD;
                end
                slave_pkg::READ_LOAD: begin
                    ready <= 1'b1;
                    state <= slave_pkg::READ_SHIFT;
                end
                slave_pkg::READ_SHIFT: begin
                    if (rd_done) begin
                        last_seen <= 1'b0;
                        if (burst && !(last_seen || last)) begin
                            addr  <= addr + slave_pkg::addr_t'(1);
                            ready <= 1'b0;
                            state <= slave_pkg::READ_FETCH;
                        end else begin
                            state <= slave_pkg::IDLE;
                        end
                    end else if (last) begin
                        last_seen <= 1'b1;
                    end
                end
                slave_pkg::WRITE_SHIFT: begin
                    // for writes only last with the final bit counts
                    if (wr_done) begin
                        last_seen <= last;
                        state     <= slave_pkg::WRITE_STORE;
                    end
                end
                slave_pkg::WRITE_STORE: begin
                    last_seen <= 1'b0;
                    if (burst && !last_seen) begin
                        addr  <= addr + slave_pkg::addr_t'(1);
                        state <= slave_pkg::WRITE_SHIFT;
                    end else begin
                        state <= slave_pkg::IDLE;
                    end
                end
                default: begin
                    ready <= 1'b1;
                    state <= slave_pkg::IDLE;
                end
            endcase
        end
    end

    assign busy     = (state != slave_pkg::IDLE);
    assign load_rd  = (state == slave_pkg::READ_LOAD);
    assign shift_rd = (state == slave_pkg::READ_SHIFT);
    assign shift_wr = (state == slave_pkg::WRITE_SHIFT) && valid;
    assign mem_we   = (state == slave_pkg::WRITE_STORE);
    assign mem_addr = addr;

    write_keeps_ready: assert property (@(posedge clk) disable iff (!rstN)
        (state == slave_pkg::WRITE_SHIFT || state == slave_pkg::WRITE_STORE) |-> ready)
        else $error("ready low during a write");

endmodule

`default_nettype wire

// ==== verilog/slave_memory.sv ====
// Slave word memory
`timescale 1ns/10ps
`default_nettype none

module slave_memory #(
    parameter int MEM_DEPTH = 2000
) (
    input  logic             clk,
    input  slave_pkg::addr_t addr,
    input  logic             we,
    input  slave_pkg::word_t wdata,
    output slave_pkg::word_t rdata
);

    slave_pkg::word_t mem [MEM_DEPTH];

    // one cycle read latency, old data on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

    addr_in_range: assert property (@(posedge clk) int'(addr) < MEM_DEPTH)
        else $error("address %0d beyond memory depth %0d", addr, MEM_DEPTH);

endmodule

`default_nettype wire

// ==== verilog/slave_pkg.sv ====
// Slave storage and control types
`default_nettype none

package slave_pkg;

    typedef logic [bus_pkg::DATA_W-1:0] word_t;
    typedef logic [bus_pkg::ADDR_W-1:0] addr_t;

    // must hold the value DATA_W itself
    typedef logic [$clog2(bus_pkg::DATA_W + 1)-1:0] bit_cnt_t;

    // transaction sequencing states
    typedef enum logic [3:0] {
        IDLE,
        READ_FETCH,
        READ_LOAD,
        READ_SHIFT,
        WRITE_SHIFT,
        WRITE_STORE
    } slave_state_t;

endpackage

`default_nettype wire
